// ==== hdl/mem_wb_pkg.sv ====
package mem_wb_pkg;

  // datapath widths
  localparam int data_w     = 32;
  localparam int reg_addr_w = 5;
  localparam int mem_op_w   = 3;

  // operation codes leaving the execute stage
  localparam logic [mem_op_w-1:0] op_none = 3'd0;
  localparam logic [mem_op_w-1:0] op_lb   = 3'd1;
  localparam logic [mem_op_w-1:0] op_lbu  = 3'd2;
  localparam logic [mem_op_w-1:0] op_lw   = 3'd3;
  localparam logic [mem_op_w-1:0] op_sb   = 3'd4;
  localparam logic [mem_op_w-1:0] op_sw   = 3'd5;

  // byte-lane select patterns
  localparam logic [3:0] sel_byte = 4'b0001;
  localparam logic [3:0] sel_word = 4'b1111;

  // one data word, seen whole or as four byte lanes
  // lanes[0] is bits 7:0, lanes[3] is bits 31:24
  typedef union packed {
    logic [data_w-1:0] word;
    logic [3:0][7:0]   lanes;
  } mem_word_t;

endpackage

// ==== hdl/mem_ctrl.sv ====
`timescale 1ns/10ps

module mem_ctrl #(
  parameter int ram_words = 256
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                in_valid,
  input  logic [mem_wb_pkg::mem_op_w-1:0]     op,
  input  logic [mem_wb_pkg::data_w-1:0]       alu_result,
  input  logic [mem_wb_pkg::reg_addr_w-1:0]   rd_addr,
  input  logic                                rd_write,
  input  logic [mem_wb_pkg::data_w-1:0]       pc,
  output logic                                mem_read,
  output logic                                mem_write,
  output logic [3:0]                          mem_sel,
  output logic [$clog2(ram_words)-1:0]        ram_addr,
  output logic                                wb_mem_read,
  output logic                                wb_ext,
  output logic [3:0]                          wb_sel,
  output logic [mem_wb_pkg::data_w-1:0]       wb_result_in,
  output logic [mem_wb_pkg::reg_addr_w-1:0]   wb_rd_addr,
  output logic                                wb_rd_write,
  output logic [mem_wb_pkg::data_w-1:0]       wb_pc
);

  localparam int ram_addr_w = $clog2(ram_words);

  logic [mem_wb_pkg::mem_op_w-1:0] op_eff;
  logic                            mem_ext;
  logic                            is_store;
  logic                            word_aligned;

  // an idle slot behaves as a no-op
  assign op_eff       = in_valid ? op : mem_wb_pkg::op_none;
  assign word_aligned = (alu_result[1:0] == 2'b00);

  // word address into the data RAM
  assign ram_addr = alu_result[ram_addr_w+1:2];

  always_comb begin
    mem_read  = 1'b0;
    mem_write = 1'b0;
    mem_ext   = 1'b0;
    mem_sel   = 4'b0000;
    is_store  = 1'b0;
    case (op_eff)
      mem_wb_pkg::op_lb: begin
        mem_read = 1'b1;
        mem_ext  = 1'b1;
        mem_sel  = mem_wb_pkg::sel_byte;
      end
      mem_wb_pkg::op_lbu: begin
        mem_read = 1'b1;
        mem_sel  = mem_wb_pkg::sel_byte;
      end
      mem_wb_pkg::op_lw: begin
        mem_read = 1'b1;
        mem_sel  = mem_wb_pkg::sel_word;
      end
      mem_wb_pkg::op_sb: begin
        mem_write = 1'b1;
        mem_sel   = mem_wb_pkg::sel_byte;
        is_store  = 1'b1;
      end
      mem_wb_pkg::op_sw: begin
        // misaligned word store is dropped
        mem_write = word_aligned;
        mem_sel   = mem_wb_pkg::sel_word;
        is_store  = 1'b1;
      end
      default: ;
    endcase
  end

  // memory to write-back stage register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_mem_read  <= 1'b0;
      wb_ext       <= 1'b0;
      wb_sel       <= 4'b0000;
      wb_result_in <= '0;
      wb_rd_addr   <= '0;
      wb_rd_write  <= 1'b0;
      wb_pc        <= '0;
    end else begin
      wb_mem_read  <= mem_read;
      wb_ext       <= mem_ext;
      wb_sel       <= mem_sel;
      wb_result_in <= alu_result;
      wb_rd_addr   <= rd_addr;
      // stores have no destination register
      wb_rd_write  <= in_valid & rd_write & ~is_store;
      wb_pc        <= pc;
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_read && mem_write));

endmodule

// ==== hdl/store_align.sv ====
`timescale 1ns/10ps

module store_align (
  input  logic                          mem_write,
  input  logic [3:0]                    mem_sel,
  input  logic [1:0]                    byte_offset,
  input  logic [mem_wb_pkg::data_w-1:0] store_data,
  output logic [mem_wb_pkg::data_w-1:0] wr_data,
  output logic [3:0]                    wr_be
);

  mem_wb_pkg::mem_word_t lane_word;

  always_comb begin
    lane_word.word = store_data;
    wr_be          = 4'b0000;
    if (mem_sel == mem_wb_pkg::sel_byte) begin
      // same byte copied into every lane, enable picks one
      for (int i = 0; i < 4; i++) begin
        lane_word.lanes[i] = store_data[7:0];
      end
      if (mem_write) begin
        wr_be = 4'b0001 << byte_offset;
      end
    end else if (mem_sel == mem_wb_pkg::sel_word) begin
      if (mem_write && byte_offset == 2'b00) begin
        wr_be = 4'b1111;
      end
    end
  end

  assign wr_data = lane_word.word;

  // RAM only ever sees a single lane or a full word
  always_comb begin
    if (wr_be != 4'b0000) begin
      a_be_shape: assert ($onehot(wr_be) || wr_be == 4'b1111);
    end
  end

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/10ps

module data_ram #(
  parameter int ram_words = 256
) (
  input  logic                          clk,
  input  logic [$clog2(ram_words)-1:0]  addr,
  input  logic [3:0]                    wr_be,
  input  logic [mem_wb_pkg::data_w-1:0] wr_data,
  input  logic                          rd_en,
  output logic [mem_wb_pkg::data_w-1:0] rd_data
);

  logic [mem_wb_pkg::data_w-1:0] mem [ram_words];

  // read returns the contents before this edge's write
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[addr];
    end
    for (int i = 0; i < 4; i++) begin
      if (wr_be[i]) begin
        mem[addr][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
  end

endmodule

// ==== hdl/load_align.sv ====
`timescale 1ns/10ps

module load_align (
  input  logic [mem_wb_pkg::data_w-1:0] ram_data,
  input  logic                          mem_read,
  input  logic                          mem_ext,
  input  logic [3:0]                    mem_sel,
  input  logic [mem_wb_pkg::data_w-1:0] result_in,
  input  logic [1:0]                    byte_offset,
  output logic [mem_wb_pkg::data_w-1:0] result_out
);

  localparam int pad_w = mem_wb_pkg::data_w - 8;

  mem_wb_pkg::mem_word_t ram_word;
  logic [7:0]            lane_byte;
  logic                  fill_bit;

  assign ram_word.word = ram_data;

  // lane chosen by the low address bits
  assign lane_byte = ram_word.lanes[byte_offset];
  assign fill_bit  = mem_ext & lane_byte[7];

  always_comb begin
    if (!mem_read) begin
      // alu result passes straight to the register file
      result_out = result_in;
    end else if (mem_sel == mem_wb_pkg::sel_byte) begin
      result_out = {{pad_w{fill_bit}}, lane_byte};
    end else if (mem_sel == mem_wb_pkg::sel_word && byte_offset == 2'b00) begin
      result_out = ram_word.word;
    end else begin
      // misaligned word load
      result_out = '0;
    end
  end

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps

module reg_file (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              we,
  input  logic [mem_wb_pkg::reg_addr_w-1:0] waddr,
  input  logic [mem_wb_pkg::data_w-1:0]     wdata,
  input  logic [mem_wb_pkg::reg_addr_w-1:0] raddr,
  output logic [mem_wb_pkg::data_w-1:0]     rdata
);

  localparam int depth = 2 ** mem_wb_pkg::reg_addr_w;

  logic [mem_wb_pkg::data_w-1:0] regs [depth];

  // writes to r0 are dropped so it keeps reading zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata = regs[raddr];

endmodule

// ==== hdl/mem_wb_top.sv ====
`timescale 1ns/10ps

module mem_wb_top #(
  parameter int ram_words = 256
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              in_valid,
  input  logic [mem_wb_pkg::mem_op_w-1:0]   op,
  input  logic [mem_wb_pkg::data_w-1:0]     alu_result,
  input  logic [mem_wb_pkg::data_w-1:0]     store_data,
  input  logic [mem_wb_pkg::reg_addr_w-1:0] rd_addr,
  input  logic                              rd_write,
  input  logic [mem_wb_pkg::data_w-1:0]     pc,
  input  logic [mem_wb_pkg::reg_addr_w-1:0] rs_addr,
  output logic [mem_wb_pkg::data_w-1:0]     wb_data,
  output logic                              wb_write,
  output logic [mem_wb_pkg::reg_addr_w-1:0] wb_addr,
  output logic [mem_wb_pkg::data_w-1:0]     debug_pc,
  output logic [mem_wb_pkg::data_w-1:0]     rs_data
);

  localparam int ram_addr_w = $clog2(ram_words);

  // memory stage strobes
  logic                          mem_read;
  logic                          mem_write;
  logic [3:0]                    mem_sel;
  logic [ram_addr_w-1:0]         ram_addr;
  logic [mem_wb_pkg::data_w-1:0] wr_data;
  logic [3:0]                    wr_be;
  logic [mem_wb_pkg::data_w-1:0] ram_rd_data;

  // write-back stage
  logic                          wb_mem_read;
  logic                          wb_ext;
  logic [3:0]                    wb_sel;
  logic [mem_wb_pkg::data_w-1:0] wb_result_in;

  mem_ctrl #(.ram_words(ram_words)) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (in_valid),
    .op           (op),
    .alu_result   (alu_result),
    .rd_addr      (rd_addr),
    .rd_write     (rd_write),
    .pc           (pc),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_sel      (mem_sel),
    .ram_addr     (ram_addr),
    .wb_mem_read  (wb_mem_read),
    .wb_ext       (wb_ext),
    .wb_sel       (wb_sel),
    .wb_result_in (wb_result_in),
    .wb_rd_addr   (wb_addr),
    .wb_rd_write  (wb_write),
    .wb_pc        (debug_pc)
  );

  store_align u_store (
    .mem_write   (mem_write),
    .mem_sel     (mem_sel),
    .byte_offset (alu_result[1:0]),
    .store_data  (store_data),
    .wr_data     (wr_data),
    .wr_be       (wr_be)
  );

  data_ram #(.ram_words(ram_words)) u_ram (
    .clk     (clk),
    .addr    (ram_addr),
    .wr_be   (wr_be),
    .wr_data (wr_data),
    .rd_en   (mem_read),
    .rd_data (ram_rd_data)
  );

  // byte offset comes from the registered effective address
  load_align u_load (
    .ram_data    (ram_rd_data),
    .mem_read    (wb_mem_read),
    .mem_ext     (wb_ext),
    .mem_sel     (wb_sel),
    .result_in   (wb_result_in),
    .byte_offset (wb_result_in[1:0]),
    .result_out  (wb_data)
  );

  reg_file u_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (wb_write),
    .waddr (wb_addr),
    .wdata (wb_data),
    .raddr (rs_addr),
    .rdata (rs_data)
  );

  // a store accepted now never shows up as a register write next cycle
  a_store_no_wb: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && (op == mem_wb_pkg::op_sb || op == mem_wb_pkg::op_sw) |=> !wb_write);

endmodule

// ==== testbench/tb_mem_wb.sv ====
`timescale 1ns/10ps

module tb_mem_wb;

  localparam int ram_words    = 256;
  localparam int reset_cycles = 4;
  localparam int fill_words   = 16;
  localparam int n_random     = 200;
  localparam int mem_bytes    = ram_words * 4;
  localparam int byte_aw      = $clog2(mem_bytes);

  logic                              clk;
  logic                              rst_n;
  logic                              in_valid;
  logic [mem_wb_pkg::mem_op_w-1:0]   op;
  logic [mem_wb_pkg::data_w-1:0]     alu_result;
  logic [mem_wb_pkg::data_w-1:0]     store_data;
  logic [mem_wb_pkg::reg_addr_w-1:0] rd_addr;
  logic                              rd_write;
  logic [mem_wb_pkg::data_w-1:0]     pc;
  logic [mem_wb_pkg::reg_addr_w-1:0] rs_addr;
  logic [mem_wb_pkg::data_w-1:0]     wb_data;
  logic                              wb_write;
  logic [mem_wb_pkg::reg_addr_w-1:0] wb_addr;
  logic [mem_wb_pkg::data_w-1:0]     debug_pc;
  logic [mem_wb_pkg::data_w-1:0]     rs_data;

  // byte-wide memory model and architectural registers
  logic [7:0]  mem_model [mem_bytes];
  logic [31:0] reg_model [32];

  // stimulus table columns
  logic [2:0]  t_op   [$];
  logic [31:0] t_addr [$];
  logic [31:0] t_data [$];
  logic [4:0]  t_rd   [$];
  logic [31:0] t_exp  [$];

  // expected outputs of the instruction in write-back
  logic        have_pending;
  logic        p_write;
  logic        p_chk;
  logic [31:0] p_data;
  logic [4:0]  p_addr;
  logic [31:0] p_pc;

  logic [31:0] pc_next;
  integer      seed;
  int          n_issued;
  int          n_checked;
  int          n_reg_reads;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  mem_wb_top #(.ram_words(ram_words)) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .op         (op),
    .alu_result (alu_result),
    .store_data (store_data),
    .rd_addr    (rd_addr),
    .rd_write   (rd_write),
    .pc         (pc),
    .rs_addr    (rs_addr),
    .wb_data    (wb_data),
    .wb_write   (wb_write),
    .wb_addr    (wb_addr),
    .debug_pc   (debug_pc),
    .rs_data    (rs_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_run($sformatf("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      stop_run("timeout: the run went past its cycle limit");
    end
  end

  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
  endfunction

  task automatic add_entry(input logic [2:0] e_op, input logic [31:0] e_addr,
                           input logic [31:0] e_data, input logic [4:0] e_rd,
                           input logic [31:0] e_exp);
    t_op.push_back(e_op);
    t_addr.push_back(e_addr);
    t_data.push_back(e_data);
    t_rd.push_back(e_rd);
    t_exp.push_back(e_exp);
  endtask

  // little-endian byte memory with lane 0 at offset 0
  task automatic model_step(input logic valid, input logic [2:0] m_op,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [4:0] rd, input logic rdw,
                            output logic [31:0] res, output logic wr, output logic chk);
    logic [2:0]         eff;
    logic [byte_aw-1:0] a;
    logic [byte_aw-1:0] wa;
    eff = valid ? m_op : mem_wb_pkg::op_none;
    a   = addr[byte_aw-1:0];
    wa  = a & {{(byte_aw-2){1'b1}}, 2'b00};
    res = addr;
    wr  = valid & rdw;
    chk = 1'b1;
    case (eff)
      mem_wb_pkg::op_lb:  res = {{24{mem_model[a][7]}}, mem_model[a]};
      mem_wb_pkg::op_lbu: res = {24'h0, mem_model[a]};
      mem_wb_pkg::op_lw: begin
        if (a[1:0] == 2'b00) begin
          res = {mem_model[wa + byte_aw'(3)], mem_model[wa + byte_aw'(2)],
                 mem_model[wa + byte_aw'(1)], mem_model[wa]};
        end else begin
          res = 32'h0;
        end
      end
      mem_wb_pkg::op_sb: begin
        mem_model[a] = data[7:0];
        wr  = 1'b0;
        chk = 1'b0;
      end
      mem_wb_pkg::op_sw: begin
        if (a[1:0] == 2'b00) begin
          for (int i = 0; i < 4; i++) begin
            mem_model[wa + byte_aw'(i)] = data[i*8 +: 8];
          end
        end
        wr  = 1'b0;
        chk = 1'b0;
      end
      default: ;
    endcase
    if (wr && rd != 5'd0) begin
      reg_model[rd] = res;
    end
  endtask

  task automatic check_pending();
    assert (wb_write === p_write)
      else report_mismatch("wb_write", 32'(wb_write), 32'(p_write));
    assert (wb_addr === p_addr)
      else report_mismatch("wb_addr", 32'(wb_addr), 32'(p_addr));
    assert (debug_pc === p_pc)
      else report_mismatch("debug_pc", debug_pc, p_pc);
    if (p_chk) begin
      assert (wb_data === p_data)
        else report_mismatch("wb_data", wb_data, p_data);
    end
    n_checked++;
  endtask

  // drive one instruction and check the one issued a cycle before
  task automatic issue(input logic valid, input logic [2:0] i_op, input logic [31:0] addr,
                       input logic [31:0] data, input logic [4:0] rd, input logic rdw,
                       input logic use_exp, input logic [31:0] exp);
    logic [31:0] res;
    logic        wr;
    logic        chk;
    @(posedge clk);
    in_valid   <= valid;
    op         <= i_op;
    alu_result <= addr;
    store_data <= data;
    rd_addr    <= rd;
    rd_write   <= rdw;
    pc         <= pc_next;
    model_step(valid, i_op, addr, data, rd, rdw, res, wr, chk);
    @(negedge clk);
    if (have_pending) begin
      check_pending();
    end
    have_pending = 1'b1;
    p_write      = wr;
    p_chk        = chk;
    p_data       = use_exp ? exp : res;
    p_addr       = rd;
    p_pc         = pc_next;
    pc_next      = pc_next + 32'd4;
    n_issued++;
  endtask

  task automatic random_op();
    logic [31:0] r;
    logic [31:0] d;
    logic [2:0]  r_op;
    logic [31:0] addr;
    logic [1:0]  off;
    r    = $random(seed);
    d    = $random(seed);
    r_op = 3'(r[15:0] % 16'd6);
    off  = r[21:20];
    // word accesses are mostly aligned
    if ((r_op == mem_wb_pkg::op_lw || r_op == mem_wb_pkg::op_sw) && r[29:28] != 2'b00) begin
      off = 2'b00;
    end
    if (r_op == mem_wb_pkg::op_none) begin
      addr = d;
    end else begin
      addr = {26'h0, r[19:16], off};
    end
    issue(r[24:22] != 3'b000, r_op, addr, d, r[31:27], r[26:25] != 2'b00, 1'b0, 32'h0);
  endtask

  task automatic build_table();
    // store then load to the same address
    add_entry(mem_wb_pkg::op_sw,   32'h0000_0100, 32'hdead_beef, 5'd5,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0100, 32'h0000_0000, 5'd6,  32'hdead_beef);
    add_entry(mem_wb_pkg::op_none, 32'h1234_5678, 32'h0000_0000, 5'd7,  32'h1234_5678);
    // byte stores with junk in the upper data bits
    add_entry(mem_wb_pkg::op_sb,   32'h0000_0200, 32'h1234_5681, 5'd2,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_sb,   32'h0000_0201, 32'hffff_ff22, 5'd3,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_sb,   32'h0000_0202, 32'h0000_00f3, 5'd4,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_sb,   32'h0000_0203, 32'haaaa_aa44, 5'd5,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_lb,   32'h0000_0200, 32'h0000_0000, 5'd8,  32'hffff_ff81);
    add_entry(mem_wb_pkg::op_lbu,  32'h0000_0200, 32'h0000_0000, 5'd9,  32'h0000_0081);
    add_entry(mem_wb_pkg::op_lb,   32'h0000_0201, 32'h0000_0000, 5'd10, 32'h0000_0022);
    add_entry(mem_wb_pkg::op_lbu,  32'h0000_0201, 32'h0000_0000, 5'd11, 32'h0000_0022);
    add_entry(mem_wb_pkg::op_lb,   32'h0000_0202, 32'h0000_0000, 5'd12, 32'hffff_fff3);
    add_entry(mem_wb_pkg::op_lbu,  32'h0000_0202, 32'h0000_0000, 5'd13, 32'h0000_00f3);
    add_entry(mem_wb_pkg::op_lb,   32'h0000_0203, 32'h0000_0000, 5'd14, 32'h0000_0044);
    add_entry(mem_wb_pkg::op_lbu,  32'h0000_0203, 32'h0000_0000, 5'd15, 32'h0000_0044);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0200, 32'h0000_0000, 5'd16, 32'h44f3_2281);
    // misaligned word accesses
    add_entry(mem_wb_pkg::op_sw,   32'h0000_0300, 32'h0bad_f00d, 5'd1,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0302, 32'h0000_0000, 5'd17, 32'h0000_0000);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0301, 32'h0000_0000, 5'd18, 32'h0000_0000);
    add_entry(mem_wb_pkg::op_sw,   32'h0000_0301, 32'hffff_ffff, 5'd1,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0300, 32'h0000_0000, 5'd19, 32'h0bad_f00d);
    add_entry(mem_wb_pkg::op_sw,   32'h0000_0303, 32'h1111_1111, 5'd1,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0300, 32'h0000_0000, 5'd20, 32'h0bad_f00d);
    // r0 as destination
    add_entry(mem_wb_pkg::op_none, 32'hcafe_babe, 32'h0000_0000, 5'd0,  32'hcafe_babe);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0100, 32'h0000_0000, 5'd0,  32'hdead_beef);
    // patch single lanes of an existing word
    add_entry(mem_wb_pkg::op_sb,   32'h0000_0101, 32'h0000_005a, 5'd21, 32'h0000_0000);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0100, 32'h0000_0000, 5'd22, 32'hdead_5aef);
    add_entry(mem_wb_pkg::op_lb,   32'h0000_0101, 32'h0000_0000, 5'd23, 32'h0000_005a);
    add_entry(mem_wb_pkg::op_sb,   32'h0000_0103, 32'h0000_0080, 5'd21, 32'h0000_0000);
    add_entry(mem_wb_pkg::op_lb,   32'h0000_0103, 32'h0000_0000, 5'd24, 32'hffff_ff80);
    add_entry(mem_wb_pkg::op_lbu,  32'h0000_0103, 32'h0000_0000, 5'd25, 32'h0000_0080);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0100, 32'h0000_0000, 5'd26, 32'h80ad_5aef);
    add_entry(mem_wb_pkg::op_none, 32'h0000_0000, 32'h0000_0000, 5'd27, 32'h0000_0000);
    add_entry(mem_wb_pkg::op_none, 32'hffff_ffff, 32'h0000_0000, 5'd28, 32'hffff_ffff);
    // top word of the RAM
    add_entry(mem_wb_pkg::op_sw,   32'h0000_03fc, 32'h7654_3210, 5'd2,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_03fc, 32'h0000_0000, 5'd29, 32'h7654_3210);
    add_entry(mem_wb_pkg::op_lbu,  32'h0000_03fe, 32'h0000_0000, 5'd30, 32'h0000_0054);
    add_entry(mem_wb_pkg::op_lb,   32'h0000_03ff, 32'h0000_0000, 5'd31, 32'h0000_0076);
    add_entry(mem_wb_pkg::op_sw,   32'h0000_0000, 32'h89ab_cdef, 5'd3,  32'h0000_0000);
    add_entry(mem_wb_pkg::op_lw,   32'h0000_0000, 32'h0000_0000, 5'd1,  32'h89ab_cdef);
  endtask

  initial begin : main
    logic [31:0] fill_addr;
    seed         = 32'h487;
    rst_n        = 1'b0;
    // nonzero inputs while in reset show that the stage register clears
    in_valid     = 1'b1;
    op           = mem_wb_pkg::op_none;
    alu_result   = 32'hffff_ffff;
    store_data   = 32'h0;
    rd_addr      = 5'd31;
    rd_write     = 1'b1;
    pc           = 32'hffff_fffc;
    rs_addr      = 5'd31;
    have_pending = 1'b0;
    pc_next      = 32'h0040_0000;
    n_issued     = 0;
    n_checked    = 0;
    n_reg_reads  = 0;
    for (int i = 0; i < 32; i++) begin
      reg_model[i] = 32'h0;
    end
    build_table();
    // reset, check cycle, every issue, drain, register reads, margin
    cycle_limit = reset_cycles + 1 + t_op.size() + fill_words + n_random + 2 + 32 + 20;

    repeat (reset_cycles) @(posedge clk);
    rst_n    <= 1'b1;
    in_valid <= 1'b0;
    rd_write <= 1'b0;
    @(negedge clk);
    assert (wb_write === 1'b0) else report_mismatch("wb_write", 32'(wb_write), 32'h0);
    assert (wb_data === 32'h0) else report_mismatch("wb_data", wb_data, 32'h0);
    assert (debug_pc === 32'h0) else report_mismatch("debug_pc", debug_pc, 32'h0);
    assert (rs_data === 32'h0) else report_mismatch("rs_data", rs_data, 32'h0);

    foreach (t_op[i]) begin
      issue(1'b1, t_op[i], t_addr[i], t_data[i], t_rd[i], 1'b1, 1'b1, t_exp[i]);
    end

    // known contents for the random region
    for (int w = 0; w < fill_words; w++) begin
      fill_addr = 32'(w * 4);
      issue(1'b1, mem_wb_pkg::op_sw, fill_addr, fill_pattern(fill_addr), 5'd1, 1'b1,
            1'b0, 32'h0);
    end

    for (int k = 0; k < n_random; k++) begin
      random_op();
    end

    // drain the pipeline so the last write lands
    issue(1'b0, mem_wb_pkg::op_none, 32'h0, 32'h0, 5'd0, 1'b0, 1'b0, 32'h0);
    issue(1'b0, mem_wb_pkg::op_none, 32'h0, 32'h0, 5'd0, 1'b0, 1'b0, 32'h0);

    for (int r = 0; r < 32; r++) begin
      @(posedge clk);
      rs_addr <= 5'(r);
      @(negedge clk);
      assert (rs_data === reg_model[r])
        else report_mismatch($sformatf("rs_data[%0d]", r), rs_data, reg_model[r]);
      n_reg_reads++;
    end

    if (n_checked == n_issued - 1 && n_reg_reads == 32) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_run("not every instruction or register read was checked");
    end
  end

endmodule

// ==== flist.f ====
hdl/mem_wb_pkg.sv
hdl/mem_ctrl.sv
hdl/store_align.sv
hdl/data_ram.sv
hdl/load_align.sv
hdl/reg_file.sv
hdl/mem_wb_top.sv
testbench/tb_mem_wb.sv

// ==== Makefile ====
# Verilator build and run for the memory and write-back back end

VERILATOR ?= verilator
TOP       ?= tb_mem_wb
RTL_TOP   ?= mem_wb_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
